//--- source/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

////////////////////////////////////////
// Fetch port
////////////////////////////////////////

// Byte address and instruction widths
`define INST_ADDR_W         32
`define INST_DATA_W         32

// Instruction memory geometry
`define INST_MEM_WORDS      256
`define INST_IDX_W          8

// Byte address of word 0
`define INST_BASE_ADDR      32'h0001_0000

////////////////////////////////////////
// UART programmer
////////////////////////////////////////

// Clock cycles per serial bit
`define PROG_CLKS_PER_BIT   16

`endif

//--- source/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

    ////////////////////////////////////////
    // Programmer receiver
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    ////////////////////////////////////////
    // Inter-module payloads
    ////////////////////////////////////////

    // Packer to SRAM write command
    typedef struct packed {
        logic                       valid;
        logic [`INST_IDX_W-1:0]     idx;
        logic [`INST_DATA_W-1:0]    data;
    } mem_wr_t;

    // First fetch stage register
    typedef struct packed {
        logic                       valid;
        logic                       oow;
        logic [`INST_IDX_W-1:0]     idx;
    } fetch_req_t;

endpackage

//--- source/prog_uart_rx.sv
`include "soc_cfg.svh"

module prog_uart_rx (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic       byte_valid_o,
    output logic [7:0] byte_o
);

    localparam int CNT_W    = $clog2(`PROG_CLKS_PER_BIT);
    localparam int BIT_LAST = `PROG_CLKS_PER_BIT - 1;
    localparam int HALF     = `PROG_CLKS_PER_BIT / 2;

    logic               rx_meta_q;
    logic               rx_sync_q;
    soc_pkg::rx_state_e state_q;
    logic [CNT_W-1:0]   clk_cnt_q;
    logic [2:0]         bit_cnt_q;
    logic [7:0]         shift_q;
    logic               byte_valid_q;

    // Two-flop synchronizer, idle line is high
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= soc_pkg::RX_IDLE;
            clk_cnt_q    <= '0;
            bit_cnt_q    <= '0;
            byte_valid_q <= 1'b0;
        end else begin
            byte_valid_q <= 1'b0;
            case (state_q)
                soc_pkg::RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rx_sync_q) begin
                        state_q <= soc_pkg::RX_START;
                    end
                end
                soc_pkg::RX_START: begin
                    // Re-check start bit at its middle
                    if (clk_cnt_q == CNT_W'(HALF - 1)) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= rx_sync_q ? soc_pkg::RX_IDLE : soc_pkg::RX_DATA;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                soc_pkg::RX_DATA: begin
                    if (clk_cnt_q == CNT_W'(BIT_LAST)) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= soc_pkg::RX_STOP;
                        end
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                soc_pkg::RX_STOP: begin
                    if (clk_cnt_q == CNT_W'(BIT_LAST)) begin
                        clk_cnt_q    <= '0;
                        state_q      <= soc_pkg::RX_IDLE;
                        // Low stop bit drops the frame
                        byte_valid_q <= rx_sync_q;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= soc_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == soc_pkg::RX_DATA && clk_cnt_q == CNT_W'(BIT_LAST)) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    assign byte_valid_o = byte_valid_q;
    assign byte_o       = shift_q;

endmodule

//--- source/prog_word_packer.sv
`include "soc_cfg.svh"

module prog_word_packer (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             enable_i,
    input  logic             byte_valid_i,
    input  logic [7:0]       byte_i,
    output soc_pkg::mem_wr_t wr_o
);

    logic [1:0]              byte_cnt_q;
    logic [`INST_IDX_W-1:0]  word_idx_q;
    logic [`INST_DATA_W-1:0] word_buf_q;
    logic [`INST_DATA_W-1:0] word_next;
    logic                    take_byte;
    logic                    word_done;
    soc_pkg::mem_wr_t        wr_q;

    // First byte ends up in bits 7:0
    assign word_next = {byte_i, word_buf_q[`INST_DATA_W-1:8]};
    assign take_byte = enable_i && byte_valid_i;
    assign word_done = take_byte && (byte_cnt_q == 2'd3);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !enable_i) begin
            byte_cnt_q <= '0;
            word_idx_q <= '0;
            wr_q.valid <= 1'b0;
        end else begin
            wr_q.valid <= word_done;
            if (take_byte) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
            // Index wraps with the memory depth
            if (word_done) begin
                word_idx_q <= word_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_byte) begin
            word_buf_q <= word_next;
        end
        if (word_done) begin
            wr_q.idx  <= word_idx_q;
            wr_q.data <= word_next;
        end
    end

    assign wr_o = wr_q;

endmodule

//--- source/instr_fetch_stage.sv
`include "soc_cfg.svh"

module instr_fetch_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    req_i,
    input  logic [`INST_ADDR_W-1:0] addr_i,
    output logic                    gnt_o,
    output soc_pkg::fetch_req_t     fetch_o
);

    localparam logic [`INST_ADDR_W-1:0] WIN_LO = `INST_BASE_ADDR;
    localparam logic [`INST_ADDR_W-1:0] WIN_HI = `INST_BASE_ADDR + 4 * `INST_MEM_WORDS;

    logic                in_window;
    soc_pkg::fetch_req_t fetch_q;

    // Every request is accepted at once
    assign gnt_o = req_i;

    assign in_window = (addr_i >= WIN_LO) && (addr_i < WIN_HI);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            fetch_q.oow <= !in_window;
            fetch_q.idx <= addr_i[`INST_IDX_W+1:2];
        end
    end

    assign fetch_o = fetch_q;

endmodule

//--- source/instr_sram.sv
`include "soc_cfg.svh"

module instr_sram (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  soc_pkg::mem_wr_t        wr_i,
    input  soc_pkg::fetch_req_t     fetch_i,
    output logic                    rvalid_o,
    output logic [`INST_DATA_W-1:0] rdata_o
);

    logic [`INST_DATA_W-1:0] mem_q [0:`INST_MEM_WORDS-1];
    logic                    rvalid_q;
    logic [`INST_DATA_W-1:0] rdata_q;

    ////////////////////////////////////////
    // Programmer write port
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_i.valid) begin
            mem_q[wr_i.idx] <= wr_i.data;
        end
    end

    ////////////////////////////////////////
    // Second fetch stage
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= fetch_i.valid;
        end
    end

    // Same-cycle write to the read word returns old data
    always_ff @(posedge clk_i) begin
        if (fetch_i.valid) begin
            if (fetch_i.oow) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= mem_q[fetch_i.idx];
            end
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

//--- source/inst_subsys_top.sv
`include "soc_cfg.svh"

module inst_subsys_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // UART programmer
    input  logic                    prog_enable_i,
    input  logic                    prog_rx_i,

    // Core fetch port
    input  logic                    instr_req_i,
    input  logic [`INST_ADDR_W-1:0] instr_addr_i,
    output logic                    instr_gnt_o,
    output logic                    instr_rvalid_o,
    output logic [`INST_DATA_W-1:0] instr_rdata_o
);

    logic                rx_byte_valid;
    logic [7:0]          rx_byte;
    soc_pkg::mem_wr_t    prog_wr;
    soc_pkg::fetch_req_t fetch_req;

    ////////////////////////////////////////
    // Loading path
    ////////////////////////////////////////

    prog_uart_rx u_prog_uart_rx (
        .clk_i        ( clk_i         ),
        .rst_n_i      ( rst_n_i       ),
        .rx_i         ( prog_rx_i     ),
        .byte_valid_o ( rx_byte_valid ),
        .byte_o       ( rx_byte       )
    );

    prog_word_packer u_prog_word_packer (
        .clk_i        ( clk_i         ),
        .rst_n_i      ( rst_n_i       ),
        .enable_i     ( prog_enable_i ),
        .byte_valid_i ( rx_byte_valid ),
        .byte_i       ( rx_byte       ),
        .wr_o         ( prog_wr       )
    );

    ////////////////////////////////////////
    // Fetch path
    ////////////////////////////////////////

    instr_fetch_stage u_instr_fetch_stage (
        .clk_i   ( clk_i        ),
        .rst_n_i ( rst_n_i      ),
        .req_i   ( instr_req_i  ),
        .addr_i  ( instr_addr_i ),
        .gnt_o   ( instr_gnt_o  ),
        .fetch_o ( fetch_req    )
    );

    instr_sram u_instr_sram (
        .clk_i    ( clk_i          ),
        .rst_n_i  ( rst_n_i        ),
        .wr_i     ( prog_wr        ),
        .fetch_i  ( fetch_req      ),
        .rvalid_o ( instr_rvalid_o ),
        .rdata_o  ( instr_rdata_o  )
    );

endmodule

//--- tb/inst_subsys_asserts.sv
module inst_subsys_asserts (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               req_i,
    input logic               gnt_i,
    input logic               rvalid_i,
    input soc_pkg::rx_state_e rx_state_i
);

    ////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////

    // Response exactly two cycles after each request
    req_gets_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(req_i, 2) |-> rvalid_i)
        else $error("fetch request without a response two cycles later");

    rvalid_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_i |-> $past(req_i, 2))
        else $error("fetch response without a request two cycles earlier");

    gnt_is_req: assert property (@(posedge clk_i) gnt_i == req_i)
        else $error("grant differs from request");

    rvalid_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !rvalid_i)
        else $error("rvalid high in the cycle after reset");

    ////////////////////////////////////////
    // UART receiver
    ////////////////////////////////////////

    rx_state_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_state_i inside {soc_pkg::RX_IDLE, soc_pkg::RX_START,
                           soc_pkg::RX_DATA, soc_pkg::RX_STOP})
        else $error("receiver state outside its enum");

endmodule

bind inst_subsys_top inst_subsys_asserts u_asserts (
    .clk_i      ( clk_i                   ),
    .rst_n_i    ( rst_n_i                 ),
    .req_i      ( instr_req_i             ),
    .gnt_i      ( instr_gnt_o             ),
    .rvalid_i   ( instr_rvalid_o          ),
    .rx_state_i ( u_prog_uart_rx.state_q  )
);

//--- tb/tb_inst_subsys.sv
`include "soc_cfg.svh"

module tb_inst_subsys;

    localparam int          CLK_HALF       = 4;
    localparam int          BIT_CLKS       = 16;
    localparam logic [31:0] SEED           = 32'h5e4a;
    localparam int          WRITE_TIMEOUT  = 2000;
    localparam int          FETCH_TIMEOUT  = 100;
    localparam int          WATCHDOG_CLKS  = 200000;
    localparam logic [31:0] WIN_END        = `INST_BASE_ADDR + 4 * `INST_MEM_WORDS;

    logic        clk;
    logic        rst_n;
    logic        prog_enable;
    logic        prog_rx;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_rdata;

    // Testbench image of the instruction memory
    logic [31:0] image [0:`INST_MEM_WORDS-1];
    logic [7:0]  load_idx;
    logic [31:0] rng_state;
    logic [31:0] exp_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] exp_word;
    int          write_count;

    inst_subsys_top dut0 (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .prog_enable_i  ( prog_enable  ),
        .prog_rx_i      ( prog_rx      ),
        .instr_req_i    ( instr_req    ),
        .instr_addr_i   ( instr_addr   ),
        .instr_gnt_o    ( instr_gnt    ),
        .instr_rvalid_o ( instr_rvalid ),
        .instr_rdata_o  ( instr_rdata  )
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping after a wrong value");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping after an error");
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected fetch data, zero outside the memory window
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `INST_BASE_ADDR;
        if (addr < `INST_BASE_ADDR || addr >= WIN_END) begin
            return 32'h0;
        end
        return image[offset[9:2]];
    endfunction

    // 8N1 frame, called on a falling edge
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        int bit_idx;
        prog_rx = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
            prog_rx = data[bit_idx];
            repeat (BIT_CLKS) @(negedge clk);
        end
        prog_rx = stop_bit;
        repeat (BIT_CLKS) @(negedge clk);
        prog_rx = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic wait_writes(input int target);
        int cycles;
        cycles = 0;
        while (write_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WRITE_TIMEOUT) begin
                report_error("timeout waiting for a memory write pulse");
            end
        end
    endtask

    // Little-endian, low byte goes out first
    task automatic load_word(input logic [31:0] word);
        int start_count;
        int b;
        start_count = write_count;
        for (b = 0; b < 4; b++) begin
            send_frame(word[8*b +: 8], 1'b1);
        end
        wait_writes(start_count + 1);
        assert (write_count == start_count + 1)
            else report_error("more than one memory write for four bytes");
        image[load_idx] = word;
        load_idx = load_idx + 8'd1;
    endtask

    task automatic drain_responses();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > FETCH_TIMEOUT) begin
                report_error("timeout with fetch responses still outstanding");
            end
        end
    endtask

    task automatic run_fetches(input bit spaced);
        logic [31:0] a;
        while (addr_q.size() != 0) begin
            a = addr_q.pop_front();
            instr_req  = 1'b1;
            instr_addr = a;
            exp_q.push_back(expected_word(a));
            @(negedge clk);
            if (spaced) begin
                instr_req = 1'b0;
                @(negedge clk);
            end
        end
        instr_req = 1'b0;
        drain_responses();
    endtask

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            write_count = 0;
        end else if (dut0.prog_wr.valid) begin
            write_count = write_count + 1;
        end
    end

    always @(negedge clk) begin
        if (rst_n && instr_rvalid) begin
            assert (exp_q.size() != 0)
                else report_error("rvalid arrived with no fetch request outstanding");
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (instr_rdata === exp_word)
                    else report_mismatch($sformatf("fetch data %08h, expected %08h",
                                                   instr_rdata, exp_word));
            end
        end
    end

    // Grant in the same cycle as the request
    always @(posedge clk) begin
        assert (instr_gnt === instr_req)
            else report_mismatch($sformatf("grant %0b, expected %0b",
                                           instr_gnt, instr_req));
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        report_error("simulation watchdog expired");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int          i;
        int          start_count;
        int          total_writes;
        logic [31:0] junk;
        rst_n       = 1'b0;
        prog_enable = 1'b0;
        prog_rx     = 1'b1;
        instr_req   = 1'b0;
        instr_addr  = 32'h0;
        rng_state   = SEED;
        load_idx    = 8'd0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // Initial image of 32 words
        prog_enable = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < 32; i++) begin
            load_word(next_rand());
        end
        for (i = 0; i < 32; i++) begin
            addr_q.push_back(`INST_BASE_ADDR + 4 * i);
        end
        run_fetches(1'b1);

        // Back-to-back, unaligned byte offsets too
        for (i = 0; i < 24; i++) begin
            addr_q.push_back(`INST_BASE_ADDR + 4 * (next_rand() % 32) + (next_rand() & 32'h3));
        end
        run_fetches(1'b0);

        // Window edges
        addr_q.push_back(`INST_BASE_ADDR - 32'd4);
        addr_q.push_back(`INST_BASE_ADDR);
        addr_q.push_back(`INST_BASE_ADDR - 32'd1);
        addr_q.push_back(`INST_BASE_ADDR - 32'd1020);
        addr_q.push_back(WIN_END);
        addr_q.push_back(WIN_END + 32'd4);
        addr_q.push_back(32'h0);
        addr_q.push_back(32'hFFFF_FFFC);
        run_fetches(1'b0);

        send_frame(8'hA5, 1'b0);
        load_word(next_rand());
        addr_q.push_back(`INST_BASE_ADDR + 4 * 32);
        addr_q.push_back(`INST_BASE_ADDR + 4 * 31);
        run_fetches(1'b1);

        // Reload from word 0 after enable toggles
        prog_enable = 1'b0;
        load_idx    = 8'd0;
        repeat (BIT_CLKS) @(negedge clk);
        start_count = write_count;
        for (i = 0; i < 4; i++) begin
            junk = next_rand();
            send_frame(junk[7:0], 1'b1);
        end
        assert (write_count == start_count)
            else report_error("bytes sent with the programmer disabled reached memory");
        prog_enable = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            load_word(next_rand());
        end
        for (i = 0; i < 33; i++) begin
            addr_q.push_back(`INST_BASE_ADDR + 4 * i);
        end
        run_fetches(1'b0);

        repeat (8) @(negedge clk);
        total_writes = 32 + 1 + 8;
        if (exp_q.size() == 0 && write_count == total_writes) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            report_error($sformatf("%0d memory writes seen, expected %0d",
                                   write_count, total_writes));
        end
    end

endmodule

//--- files.f
+incdir+source
source/soc_pkg.sv
source/prog_uart_rx.sv
source/prog_word_packer.sv
source/instr_fetch_stage.sv
source/instr_sram.sv
source/inst_subsys_top.sv
tb/inst_subsys_asserts.sv
tb/tb_inst_subsys.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f files.f --top-module tb_inst_subsys

status=0
./obj_dir/Vtb_inst_subsys > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation finished without failure"
